// ==== hdl/mm_params.svh ====
`ifndef MM_PARAMS_SVH
`define MM_PARAMS_SVH

// vector shape
`define MM_LANES     4
`define MM_ELEM_W    32

// buffer address widths
`define MM_IN_AW     11
`define MM_W_AW      13
`define MM_B_AW      9

// loop count widths
`define MM_CNT_W     8
`define MM_NODE_W    16

// pipeline latencies in cycles
// buffers answer one cycle after the read strobe
`define MM_MEM_LAT   1
`define MM_MV_LAT    2

`endif

// ==== hdl/mm_pkg.sv ====
`include "mm_params.svh"

package mm_pkg;

   // one signed element, products and sums wrap at this width
   typedef logic signed [`MM_ELEM_W-1:0] elem_t;

   // element i sits at the low end first
   typedef elem_t [`MM_LANES-1:0] vec_t;

   // row j holds elements j*LANES .. j*LANES+LANES-1
   typedef elem_t [`MM_LANES*`MM_LANES-1:0] wblk_t;

   typedef logic [`MM_IN_AW-1:0]  in_addr_t;
   typedef logic [`MM_W_AW-1:0]   w_addr_t;
   typedef logic [`MM_B_AW-1:0]   b_addr_t;
   typedef logic [`MM_CNT_W-1:0]  cnt_t;
   typedef logic [`MM_NODE_W-1:0] node_t;

endpackage

// ==== hdl/mm_beat_if.sv ====
interface mm_beat_if;

   // one beat of the stream, valid for a single cycle
   logic             valid;
   logic             first;
   logic             last;
   mm_pkg::in_addr_t out_addr;
   mm_pkg::vec_t     data;

   modport src (
      output valid,
      output first,
      output last,
      output out_addr,
      output data
   );

   modport dst (
      input valid,
      input first,
      input last,
      input out_addr,
      input data
   );

endinterface

// ==== hdl/mm_ctrl.sv ====
`include "mm_params.svh"

module mm_ctrl (
   input  logic             clk,
   input  logic             rstn,
   input  logic             start,
   input  logic             relu,
   input  logic             bias_en,
   input  mm_pkg::w_addr_t  weight_start_addr,
   input  mm_pkg::in_addr_t input_start_addr,
   input  mm_pkg::in_addr_t output_start_addr,
   input  mm_pkg::b_addr_t  bias_start_addr,
   input  mm_pkg::cnt_t     ci_count,
   input  mm_pkg::cnt_t     co_count,
   input  mm_pkg::node_t    node_count,
   output logic             input_addr_valid,
   output mm_pkg::in_addr_t input_addr,
   output logic             weight_addr_valid,
   output mm_pkg::w_addr_t  weight_addr,
   output logic             bias_addr_valid,
   output mm_pkg::b_addr_t  bias_addr,
   output logic             relu_en,
   output logic             done,
   mm_beat_if.src           beat
);

   // last read to done: memory, matvec, accum register, done register
   localparam int unsigned DRAIN   = `MM_MEM_LAT + `MM_MV_LAT + 1;
   localparam int unsigned DRAIN_W = $clog2(DRAIN + 1);

   logic               busy;
   logic               bias_on;
   logic [DRAIN_W-1:0] drain;
   mm_pkg::cnt_t       ci;
   mm_pkg::cnt_t       co;
   mm_pkg::node_t      n;
   mm_pkg::cnt_t       ci_cnt;
   mm_pkg::cnt_t       co_cnt;
   mm_pkg::node_t      n_cnt;
   mm_pkg::in_addr_t   in_addr;
   mm_pkg::in_addr_t   out_addr;
   mm_pkg::w_addr_t    w_addr;
   mm_pkg::w_addr_t    w_base;
   mm_pkg::b_addr_t    b_base;
   logic               bias_rd_d;
   mm_pkg::cnt_t       bias_co_d;
   logic               last_ci;
   logic               last_co;
   logic               last_n;
   logic               accept;

   assign last_ci = (ci == ci_cnt - 1'b1);
   assign last_co = (co == co_cnt - 1'b1);
   assign last_n  = (n == n_cnt - 1'b1);
   // start only counts once the previous run has drained
   assign accept  = start && !busy && (drain == '0);

   assign input_addr_valid  = busy;
   assign input_addr        = in_addr;
   assign weight_addr_valid = busy;
   assign weight_addr       = w_addr;

   //////////////////////////////////////////////////
   // loop counters and run state
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         busy    <= 1'b0;
         bias_on <= 1'b0;
         relu_en <= 1'b0;
         ci      <= '0;
         co      <= '0;
         n       <= '0;
         drain   <= '0;
         done    <= 1'b0;
      end else begin
         done <= (drain == DRAIN_W'(1));
         if (accept) begin
            busy    <= 1'b1;
            bias_on <= bias_en;
            relu_en <= relu;
            ci      <= '0;
            co      <= '0;
            n       <= '0;
         end else if (busy) begin
            if (!last_ci) begin
               ci <= ci + 1'b1;
            end else begin
               ci <= '0;
               if (!last_co) begin
                  co <= co + 1'b1;
               end else begin
                  co <= '0;
                  if (!last_n) begin
                     n <= n + 1'b1;
                  end else begin
                     busy  <= 1'b0;
                     drain <= DRAIN_W'(DRAIN);
                  end
               end
            end
         end else if (drain != '0) begin
            drain <= drain - 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // addresses
   always_ff @(posedge clk) begin
      if (accept) begin
         ci_cnt   <= ci_count;
         co_cnt   <= co_count;
         n_cnt    <= node_count;
         in_addr  <= input_start_addr;
         out_addr <= output_start_addr;
         w_addr   <= weight_start_addr;
         w_base   <= weight_start_addr;
         b_base   <= bias_start_addr;
      end else if (busy) begin
         // rewind to the node's first word for the next co
         if (last_ci && !last_co) begin
            in_addr <= in_addr - mm_pkg::in_addr_t'(ci);
         end else begin
            in_addr <= in_addr + 1'b1;
         end
         if (last_ci && last_co) begin
            w_addr <= w_base;
         end else begin
            w_addr <= w_addr + 1'b1;
         end
         if (last_ci) begin
            out_addr <= out_addr + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // bias read, two cycles behind the last ci read
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         bias_rd_d       <= 1'b0;
         bias_addr_valid <= 1'b0;
         beat.valid      <= 1'b0;
      end else begin
         bias_rd_d       <= busy && bias_on && last_ci;
         bias_addr_valid <= bias_rd_d;
         beat.valid      <= busy;
      end
   end

   always_ff @(posedge clk) begin
      bias_co_d     <= co;
      bias_addr     <= b_base + mm_pkg::b_addr_t'(bias_co_d);
      // tags line up with the returning buffer data
      beat.first    <= (ci == '0);
      beat.last     <= last_ci;
      beat.out_addr <= out_addr;
   end

   // all reads, bias included, are over by the time done fires
   assert property (@(posedge clk) disable iff (!rstn)
      done |-> !input_addr_valid && !weight_addr_valid && !bias_addr_valid);

   assert property (@(posedge clk) disable iff (!rstn) done |=> !done);

endmodule

// ==== hdl/mm_matvec.sv ====
`include "mm_params.svh"

module mm_matvec (
   input  logic          clk,
   input  logic          rstn,
   input  mm_pkg::wblk_t weight_data,
   mm_beat_if.dst        beat_in,
   mm_beat_if.src        beat_out
);

   localparam int L   = `MM_LANES;
   localparam int LAT = `MM_MV_LAT;

   mm_pkg::wblk_t    prod;
   mm_pkg::vec_t     sum;
   logic [LAT-1:0]   v_sr;
   logic [LAT-1:0]   first_sr;
   logic [LAT-1:0]   last_sr;
   mm_pkg::in_addr_t addr_sr [LAT];

   // pairwise tree over one row of products
   function automatic mm_pkg::elem_t row_sum(input mm_pkg::wblk_t p, input int row);
      mm_pkg::elem_t t [L];
      for (int k = 0; k < L; k++) begin
         t[k] = p[row*L+k];
      end
      for (int w = L / 2; w > 0; w = w / 2) begin
         for (int k = 0; k < w; k++) begin
            t[k] = t[2*k] + t[2*k+1];
         end
      end
      return t[0];
   endfunction

   always_ff @(posedge clk) begin
      for (int i = 0; i < L*L; i++) begin
         prod[i] <= beat_in.data[i % L] * weight_data[i];
      end
      for (int j = 0; j < L; j++) begin
         sum[j] <= row_sum(prod, j);
      end
      first_sr[0] <= beat_in.first;
      last_sr[0]  <= beat_in.last;
      addr_sr[0]  <= beat_in.out_addr;
      for (int s = 1; s < LAT; s++) begin
         first_sr[s] <= first_sr[s-1];
         last_sr[s]  <= last_sr[s-1];
         addr_sr[s]  <= addr_sr[s-1];
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         v_sr <= '0;
      end else begin
         v_sr <= {v_sr[LAT-2:0], beat_in.valid};
      end
   end

   assign beat_out.valid    = v_sr[LAT-1];
   assign beat_out.first    = first_sr[LAT-1];
   assign beat_out.last     = last_sr[LAT-1];
   assign beat_out.out_addr = addr_sr[LAT-1];
   assign beat_out.data     = sum;

   // a continuing beat follows straight on from the one before
   assert property (@(posedge clk) disable iff (!rstn)
      beat_in.valid && !beat_in.first |-> $past(beat_in.valid));

endmodule

// ==== hdl/mm_accum.sv ====
`include "mm_params.svh"

module mm_accum (
   input  logic             clk,
   input  logic             rstn,
   mm_beat_if.dst           beat,
   input  mm_pkg::vec_t     bias_data,
   input  logic             bias_data_valid,
   input  logic             relu_en,
   output logic             output_data_valid,
   output mm_pkg::vec_t     output_data,
   output mm_pkg::in_addr_t output_addr
);

   localparam int L = `MM_LANES;

   mm_pkg::vec_t psum;
   mm_pkg::vec_t sum_next;
   mm_pkg::vec_t word;

   //////////////////////////////////////////////////
   // running sum over ci, then bias and relu
   always_comb begin
      for (int i = 0; i < L; i++) begin
         if (beat.first) begin
            sum_next[i] = beat.data[i];
         end else begin
            sum_next[i] = psum[i] + beat.data[i];
         end
         if (bias_data_valid) begin
            word[i] = sum_next[i] + bias_data[i];
         end else begin
            word[i] = sum_next[i];
         end
         // zero anything with the sign bit set
         if (relu_en && word[i][`MM_ELEM_W-1]) begin
            word[i] = '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (beat.valid) begin
         psum <= sum_next;
      end
      if (beat.valid && beat.last) begin
         output_data <= word;
         output_addr <= beat.out_addr;
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         output_data_valid <= 1'b0;
      end else begin
         output_data_valid <= beat.valid && beat.last;
      end
   end

   // bias data has to arrive together with the closing beat
   assert property (@(posedge clk) disable iff (!rstn)
      bias_data_valid |-> beat.valid && beat.last);

endmodule

// ==== hdl/mm_top.sv ====
module mm_top (
   input  logic             clk,
   input  logic             rstn,

   // run control
   input  logic             start_valid,
   input  logic             b,
   input  logic             r,
   output logic             done,

   // sizes and buffer bases
   input  mm_pkg::w_addr_t  weight_start_addr,
   input  mm_pkg::in_addr_t input_start_addr,
   input  mm_pkg::in_addr_t output_start_addr,
   input  mm_pkg::b_addr_t  bias_start_addr,
   input  mm_pkg::cnt_t     ci_count,
   input  mm_pkg::cnt_t     co_count,
   input  mm_pkg::node_t    node_count,

   // input buffer
   output logic             input_addr_valid,
   output mm_pkg::in_addr_t input_addr,
   input  mm_pkg::vec_t     input_data,

   // weight buffer
   output logic             weight_addr_valid,
   output mm_pkg::w_addr_t  weight_addr,
   input  mm_pkg::wblk_t    weight_data,

   // bias buffer
   output logic             bias_addr_valid,
   output mm_pkg::b_addr_t  bias_addr,
   input  mm_pkg::vec_t     bias_data,
   input  logic             bias_data_valid,

   // output buffer
   output logic             output_data_valid,
   output mm_pkg::vec_t     output_data,
   output mm_pkg::in_addr_t output_addr
);

   logic relu_en;

   mm_beat_if beat_mv ();
   mm_beat_if beat_acc ();

   // input words come straight from the buffer alongside the tags
   assign beat_mv.data = input_data;

   mm_ctrl mm_ctrl_i (
      .clk               (clk),
      .rstn              (rstn),
      .start             (start_valid),
      .relu              (r),
      .bias_en           (b),
      .weight_start_addr (weight_start_addr),
      .input_start_addr  (input_start_addr),
      .output_start_addr (output_start_addr),
      .bias_start_addr   (bias_start_addr),
      .ci_count          (ci_count),
      .co_count          (co_count),
      .node_count        (node_count),
      .input_addr_valid  (input_addr_valid),
      .input_addr        (input_addr),
      .weight_addr_valid (weight_addr_valid),
      .weight_addr       (weight_addr),
      .bias_addr_valid   (bias_addr_valid),
      .bias_addr         (bias_addr),
      .relu_en           (relu_en),
      .done              (done),
      .beat              (beat_mv)
   );

   mm_matvec mm_matvec_i (
      .clk         (clk),
      .rstn        (rstn),
      .weight_data (weight_data),
      .beat_in     (beat_mv),
      .beat_out    (beat_acc)
   );

   mm_accum mm_accum_i (
      .clk               (clk),
      .rstn              (rstn),
      .beat              (beat_acc),
      .bias_data         (bias_data),
      .bias_data_valid   (bias_data_valid),
      .relu_en           (relu_en),
      .output_data_valid (output_data_valid),
      .output_data       (output_data),
      .output_addr       (output_addr)
   );

endmodule

// ==== sim/mm_tb.sv ====
`include "mm_params.svh"

module mm_tb;

   localparam int L  = `MM_LANES;
   localparam int VW = `MM_LANES * `MM_ELEM_W;
   // twice the sum over runs of reads plus 20 cycles of slack
   localparam int LIMIT = 2 * ((1 + 20) + (18 + 20) + (12 + 20)
                               + (16 + 20) + (6 + 20) + (12 + 20));

   logic             clk = 1'b0;
   logic             rstn;
   logic             start_valid;
   logic             b;
   logic             r;
   logic             done;
   mm_pkg::w_addr_t  weight_start_addr;
   mm_pkg::in_addr_t input_start_addr;
   mm_pkg::in_addr_t output_start_addr;
   mm_pkg::b_addr_t  bias_start_addr;
   mm_pkg::cnt_t     ci_count;
   mm_pkg::cnt_t     co_count;
   mm_pkg::node_t    node_count;
   logic             input_addr_valid;
   mm_pkg::in_addr_t input_addr;
   mm_pkg::vec_t     input_data = '0;
   logic             weight_addr_valid;
   mm_pkg::w_addr_t  weight_addr;
   mm_pkg::wblk_t    weight_data = '0;
   logic             bias_addr_valid;
   mm_pkg::b_addr_t  bias_addr;
   mm_pkg::vec_t     bias_data = '0;
   logic             bias_data_valid = 1'b0;
   logic             output_data_valid;
   mm_pkg::vec_t     output_data;
   mm_pkg::in_addr_t output_addr;

   mm_pkg::vec_t     in_mem [2**`MM_IN_AW];
   mm_pkg::wblk_t    w_mem [2**`MM_W_AW];
   mm_pkg::vec_t     b_mem [2**`MM_B_AW];
   mm_pkg::in_addr_t in_rd;
   mm_pkg::w_addr_t  w_rd;
   mm_pkg::b_addr_t  b_rd;
   logic             in_ok = 1'b0;
   logic             w_ok = 1'b0;
   logic             b_req = 1'b0;
   mm_pkg::vec_t     exp_data [$];
   mm_pkg::in_addr_t exp_addr [$];
   logic [31:0]      rng = 32'hcb3b5cd6;
   int               errors = 0;
   int               checks = 0;
   int               dones = 0;
   int               reads = 0;
   int               cycles = 0;

   mm_top mm_top_i (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // expected word (n, co) straight from the buffer contents
   function automatic mm_pkg::vec_t ref_word(input int n, input int co, input int cin,
                                             input int in_b, input int w_b, input int b_a,
                                             input bit bias, input bit relu);
      mm_pkg::vec_t  acc;
      mm_pkg::vec_t  x;
      mm_pkg::wblk_t w;
      acc = '0;
      for (int ci = 0; ci < cin; ci++) begin
         x = in_mem[in_b + n * cin + ci];
         w = w_mem[w_b + co * cin + ci];
         for (int j = 0; j < L; j++) begin
            for (int k = 0; k < L; k++) begin
               acc[j] = acc[j] + x[k] * w[j*L+k];
            end
         end
      end
      for (int j = 0; j < L; j++) begin
         if (bias) begin
            acc[j] = acc[j] + b_mem[b_a][j];
         end
         if (relu && acc[j][`MM_ELEM_W-1]) begin
            acc[j] = '0;
         end
      end
      return acc;
   endfunction

   task automatic check_value(input string what, input logic [VW-1:0] got,
                              input logic [VW-1:0] exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH time=%0t %s got=%h expected=%h", $time, what, got, exp);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // buffer models answer one cycle after the read strobe
   always @(negedge clk) begin
      input_data      <= in_ok ? in_mem[in_rd] : 'x;
      weight_data     <= w_ok ? w_mem[w_rd] : 'x;
      bias_data       <= b_req ? b_mem[b_rd] : 'x;
      bias_data_valid <= b_req;
      in_rd           <= input_addr;
      w_rd            <= weight_addr;
      b_rd            <= bias_addr;
      in_ok           <= input_addr_valid;
      w_ok            <= weight_addr_valid;
      b_req           <= bias_addr_valid;
      if (input_addr_valid || weight_addr_valid) begin
         reads++;
         check_value("weight_addr_valid", weight_addr_valid, input_addr_valid);
      end
   end

   // output compare and done watch
   always @(negedge clk) begin
      if (rstn) begin
         if (done) begin
            dones++;
            if (exp_data.size() != 0) begin
               $display("done came before the last output word at time %0t", $time);
               errors++;
            end
         end
         if (output_data_valid && exp_data.size() == 0) begin
            $display("unexpected output word at time %0t, address %0d", $time, output_addr);
            errors++;
         end else if (output_data_valid) begin
            check_value("output_data", output_data, exp_data.pop_front());
            check_value("output_addr", output_addr, exp_addr.pop_front());
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == LIMIT) begin
         $display("timeout: the runs did not finish within %0d cycles", LIMIT);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   task automatic run_case(input int id, input string name, input int nn, input int con,
                           input int cin, input bit bias, input bit relu, input bit poke);
      int e0;
      int in_b;
      int w_b;
      int b_b;
      int o_b;
      e0   = errors;
      in_b = 16 * id;
      w_b  = 100 * id;
      b_b  = 7 * id;
      o_b  = 1024 + 64 * id;
      for (int n = 0; n < nn; n++) begin
         for (int co = 0; co < con; co++) begin
            exp_data.push_back(ref_word(n, co, cin, in_b, w_b, b_b + co, bias, relu));
            exp_addr.push_back(mm_pkg::in_addr_t'(o_b + n * con + co));
         end
      end
      @(negedge clk);
      dones             = 0;
      reads             = 0;
      start_valid       = 1'b1;
      b                 = bias;
      r                 = relu;
      node_count        = nn;
      co_count          = con;
      ci_count          = cin;
      input_start_addr  = in_b;
      weight_start_addr = w_b;
      bias_start_addr   = b_b;
      output_start_addr = o_b;
      @(negedge clk);
      start_valid = 1'b0;
      if (poke) begin
         // second start with other sizes in mid run
         repeat (3) @(negedge clk);
         start_valid       = 1'b1;
         b                 = ~bias;
         r                 = ~relu;
         node_count        = 1;
         co_count          = 1;
         ci_count          = 1;
         output_start_addr = '0;
         @(negedge clk);
         start_valid = 1'b0;
      end
      do @(negedge clk); while (!done);
      repeat (6) @(negedge clk);
      @(posedge clk);
      check_value("done pulses", dones, 1);
      check_value("read count", reads, nn * con * cin);
      if (exp_data.size() != 0) begin
         $display("test %0d: %0d expected words never came out", id, exp_data.size());
         errors++;
         exp_data.delete();
         exp_addr.delete();
      end
      if (errors == e0) begin
         $display("test %0d %s: ok", id, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", id, name, errors - e0);
      end
   endtask

   initial begin
      rstn              = 1'b0;
      start_valid       = 1'b0;
      b                 = 1'b0;
      r                 = 1'b0;
      weight_start_addr = '0;
      input_start_addr  = '0;
      output_start_addr = '0;
      bias_start_addr   = '0;
      ci_count          = '0;
      co_count          = '0;
      node_count        = '0;
      for (int a = 0; a < 2**`MM_IN_AW; a++) begin
         for (int e = 0; e < L; e++) begin
            rng          = xorshift(rng);
            in_mem[a][e] = rng;
         end
      end
      for (int a = 0; a < 2**`MM_W_AW; a++) begin
         for (int e = 0; e < L * L; e++) begin
            rng         = xorshift(rng);
            w_mem[a][e] = rng;
         end
      end
      for (int a = 0; a < 2**`MM_B_AW; a++) begin
         for (int e = 0; e < L; e++) begin
            rng         = xorshift(rng);
            b_mem[a][e] = rng;
         end
      end
      repeat (3) @(negedge clk);
      rstn = 1'b1;
      run_case(1, "single block product", 1, 1, 1, 1'b0, 1'b0, 1'b0);
      run_case(2, "three nodes, two co, three ci", 3, 2, 3, 1'b0, 1'b0, 1'b0);
      run_case(3, "bias add", 2, 3, 2, 1'b1, 1'b0, 1'b0);
      run_case(4, "bias and relu", 2, 2, 4, 1'b1, 1'b1, 1'b0);
      run_case(5, "single done pulse", 2, 3, 1, 1'b0, 1'b1, 1'b0);
      run_case(6, "start while busy", 2, 2, 3, 1'b0, 1'b0, 1'b1);
      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/mm_pkg.sv
hdl/mm_beat_if.sv
hdl/mm_ctrl.sv
hdl/mm_matvec.sv
hdl/mm_accum.sv
hdl/mm_top.sv
sim/mm_tb.sv

// ==== Bender.yml ====
package:
  name: mm_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mm_pkg.sv
      - hdl/mm_beat_if.sv
      - hdl/mm_ctrl.sv
      - hdl/mm_matvec.sv
      - hdl/mm_accum.sv
      - hdl/mm_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - sim/mm_tb.sv
